// ==== memPipe_cfg.svh ====
// **************************************************
// Configuration macros for the memory back end:
// data width, RAM depth and reset PC value.
// **************************************************

`ifndef MEM_PIPE_CFG_SVH
`define MEM_PIPE_CFG_SVH

// Data and address width in bits.
`define MEM_DATA_W 32

// Number of 32-bit words in the data RAM.
`define MEM_DEPTH_WORDS 256

// PC value held in the stage registers after reset.
`define RESET_PC 32'h0000_0000

`endif

// ==== memPipe_pkg.sv ====
// **************************************************
// Shared types for the memory back end: memory op,
// write-back select and exception codes, plus the
// MEM2 and write-back stage bundles.
// **************************************************

`include "memPipe_cfg.svh"

package memPipe_pkg;

    // Memory operation decoded in the MEM stage.
    typedef enum logic [3:0] {
        opNone = 4'd0,
        opLb   = 4'd1,
        opLbu  = 4'd2,
        opLh   = 4'd3,
        opLhu  = 4'd4,
        opLw   = 4'd5,
        opSb   = 4'd6,
        opSh   = 4'd7,
        opSw   = 4'd8
    } memOpType;

    // Source of the register write-back value.
    typedef enum logic [1:0] {
        aluResult = 2'd0,
        loadData  = 2'd1,
        linkPc    = 2'd2
    } wbSelType;

    // MIPS ExcCode values for address errors.
    typedef enum logic [4:0] {
        excNone = 5'd0,
        excAdEL = 5'd4,
        excAdES = 5'd5
    } excType;

    // Instruction state carried into the second memory stage.
    typedef struct packed {
        logic [`MEM_DATA_W-1:0] aluOut;
        logic [`MEM_DATA_W-1:0] pc;
        memOpType               memOp;
        wbSelType               wbSel;
        logic [4:0]             dst;
        logic                   regWr;
        excType                 exc;
    } mem2Bundle;

    // Register-file write port and trailing status.
    typedef struct packed {
        logic                   regWr;
        logic [4:0]             dst;
        logic [`MEM_DATA_W-1:0] data;
        logic [`MEM_DATA_W-1:0] pc;
        excType                 exc;
    } wbBundle;

endpackage

// ==== memReqIf.sv ====
// **************************************************
// Data-memory request interface between the store
// formatter and the RAM.
// **************************************************

`timescale 1ns/1ns

`include "memPipe_cfg.svh"

interface memReqIf;

    logic                   en;
    logic                   we;
    logic [`MEM_DATA_W-1:0] addr;
    logic [3:0]             byteEn;
    logic [`MEM_DATA_W-1:0] wrData;

    // Request side, driven by the MEM stage.
    modport master (output en, we, addr, byteEn, wrData);

    // RAM side.
    modport slave (input en, we, addr, byteEn, wrData);

endinterface

// ==== pipeReg.sv ====
// **************************************************
// Generic pipeline stage register with async reset,
// synchronous flush and write enable.
// **************************************************

`timescale 1ns/1ns

module pipeReg #(
    parameter type payloadType = logic
) (
    input  logic       clk,
    input  logic       arstN,
    input  logic       flush,
    input  logic       wr,
    input  payloadType d,
    output payloadType q
);

    // Flush wins over write so a killed instruction becomes a bubble.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (wr) begin
            q <= d;
        end
    end

endmodule

// ==== memAccessStage.sv ====
// **************************************************
// MEM stage: alignment check, byte enables, store
// lane formatting and the MEM2 bundle.
// **************************************************

`timescale 1ns/1ns

`include "memPipe_cfg.svh"

module memAccessStage (
    input  logic [`MEM_DATA_W-1:0] aluOut,
    input  logic [`MEM_DATA_W-1:0] storeData,
    input  logic [`MEM_DATA_W-1:0] pc,
    input  memPipe_pkg::memOpType  memOp,
    input  memPipe_pkg::wbSelType  wbSel,
    input  logic [4:0]             dst,
    input  logic                   regWr,
    input  logic                   stall,
    input  logic                   flush,
    memReqIf.master                req,
    output memPipe_pkg::mem2Bundle mem2
);

    logic                   isLoad;
    logic                   isStore;
    logic                   misaligned;
    logic [3:0]             byteEn;
    logic [`MEM_DATA_W-1:0] laneData;

    always_comb begin
        isLoad     = 1'b0;
        isStore    = 1'b0;
        misaligned = 1'b0;
        byteEn     = 4'b0000;
        laneData   = storeData;
        unique case (memOp)
            memPipe_pkg::opLb, memPipe_pkg::opLbu: begin
                isLoad = 1'b1;
            end
            memPipe_pkg::opLh, memPipe_pkg::opLhu: begin
                isLoad     = 1'b1;
                misaligned = aluOut[0];
            end
            memPipe_pkg::opLw: begin
                isLoad     = 1'b1;
                misaligned = |aluOut[1:0];
            end
            memPipe_pkg::opSb: begin
                isStore  = 1'b1;
                byteEn   = 4'b0001 << aluOut[1:0];
                laneData = {4{storeData[7:0]}};
            end
            memPipe_pkg::opSh: begin
                isStore    = 1'b1;
                misaligned = aluOut[0];
                byteEn     = aluOut[1] ? 4'b1100 : 4'b0011;
                laneData   = {2{storeData[15:0]}};
            end
            memPipe_pkg::opSw: begin
                isStore    = 1'b1;
                misaligned = |aluOut[1:0];
                byteEn     = 4'b1111;
            end
            default: begin
            end
        endcase
    end

    // A fault, a stall or a flush keeps the RAM idle.
    assign req.en     = (isLoad | isStore) & ~misaligned & ~stall & ~flush;
    assign req.we     = isStore;
    assign req.addr   = aluOut;
    assign req.byteEn = byteEn;
    assign req.wrData = laneData;

    assign mem2.aluOut = aluOut;
    assign mem2.pc     = pc;
    assign mem2.memOp  = memOp;
    assign mem2.wbSel  = wbSel;
    assign mem2.dst    = dst;
    assign mem2.regWr  = regWr & ~misaligned;
    assign mem2.exc    = !misaligned ? memPipe_pkg::excNone
                       : isStore     ? memPipe_pkg::excAdES
                       : memPipe_pkg::excAdEL;

endmodule

// ==== dataRam.sv ====
// **************************************************
// Single-port data RAM with byte write enables
// and a registered read.
// **************************************************

`timescale 1ns/1ns

`include "memPipe_cfg.svh"

module dataRam (
    input  logic                   clk,
    memReqIf.slave                 req,
    output logic [`MEM_DATA_W-1:0] rdData
);

    localparam int laneCount = `MEM_DATA_W / 8;
    localparam int idxW      = $clog2(`MEM_DEPTH_WORDS);

    logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH_WORDS];
    logic [idxW-1:0]        wordIdx;

    // Word index wraps modulo the depth.
    assign wordIdx = req.addr[idxW+1:2];

    // Read returns the word as it was before this cycle's write.
    always_ff @(posedge clk) begin
        if (req.en) begin
            if (req.we) begin
                for (int i = 0; i < laneCount; i++) begin
                    if (req.byteEn[i]) begin
                        mem[wordIdx][8*i +: 8] <= req.wrData[8*i +: 8];
                    end
                end
            end
            rdData <= mem[wordIdx];
        end
    end

endmodule

// ==== loadWriteback.sv ====
// **************************************************
// MEM2 stage: load lane extraction, sign or zero
// extension and write-back value select.
// **************************************************

`timescale 1ns/1ns

`include "memPipe_cfg.svh"

module loadWriteback (
    input  memPipe_pkg::mem2Bundle mem2,
    input  logic [`MEM_DATA_W-1:0] rdData,
    output memPipe_pkg::wbBundle   wb
);

    logic [7:0]             loadByte;
    logic [15:0]            loadHalf;
    logic [`MEM_DATA_W-1:0] loadVal;
    logic [`MEM_DATA_W-1:0] wbData;

    // Little-endian lanes picked by the low address bits.
    assign loadByte = rdData[8*mem2.aluOut[1:0] +: 8];
    assign loadHalf = mem2.aluOut[1] ? rdData[31:16] : rdData[15:0];

    always_comb begin
        unique case (mem2.memOp)
            memPipe_pkg::opLb:  loadVal = {{24{loadByte[7]}}, loadByte};
            memPipe_pkg::opLbu: loadVal = {24'h000000, loadByte};
            memPipe_pkg::opLh:  loadVal = {{16{loadHalf[15]}}, loadHalf};
            memPipe_pkg::opLhu: loadVal = {16'h0000, loadHalf};
            default:            loadVal = rdData;
        endcase
    end

    always_comb begin
        unique case (mem2.wbSel)
            memPipe_pkg::loadData: wbData = loadVal;
            // Return address skips the delay slot.
            memPipe_pkg::linkPc:   wbData = mem2.pc + 32'd8;
            default:               wbData = mem2.aluOut;
        endcase
    end

    assign wb.regWr = mem2.regWr;
    assign wb.dst   = mem2.dst;
    assign wb.data  = wbData;
    assign wb.pc    = mem2.pc;
    assign wb.exc   = mem2.exc;

endmodule

// ==== memPipe.sv ====
// **************************************************
// Memory back end top: MEM stage, MEM2 register,
// data RAM, load/write-back logic and WB register.
// **************************************************

`timescale 1ns/1ns

`include "memPipe_cfg.svh"

module memPipe (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   stall,
    input  logic                   flush,
    input  logic [`MEM_DATA_W-1:0] aluOut,
    input  logic [`MEM_DATA_W-1:0] storeData,
    input  logic [`MEM_DATA_W-1:0] pc,
    input  memPipe_pkg::memOpType  memOp,
    input  memPipe_pkg::wbSelType  wbSel,
    input  logic [4:0]             dst,
    input  logic                   regWr,
    output logic                   wbRegWr,
    output logic [4:0]             wbDst,
    output logic [`MEM_DATA_W-1:0] wbData,
    output logic [`MEM_DATA_W-1:0] wbPc,
    output memPipe_pkg::excType    wbExc
);

    memPipe_pkg::mem2Bundle mem2Next;
    memPipe_pkg::mem2Bundle mem2Q;
    memPipe_pkg::wbBundle   wbNext;
    memPipe_pkg::wbBundle   wbQ;
    logic [`MEM_DATA_W-1:0] rdData;
    logic                   stageWr;

    memReqIf memReq ();

    // Both registers advance together unless stalled.
    assign stageWr = ~stall;

    memAccessStage memAccessStage_inst (
        .aluOut    (aluOut),
        .storeData (storeData),
        .pc        (pc),
        .memOp     (memOp),
        .wbSel     (wbSel),
        .dst       (dst),
        .regWr     (regWr),
        .stall     (stall),
        .flush     (flush),
        .req       (memReq.master),
        .mem2      (mem2Next)
    );

    pipeReg #(
        .payloadType (memPipe_pkg::mem2Bundle)
    ) mem2Reg_inst (
        .clk   (clk),
        .arstN (arstN),
        .flush (flush),
        .wr    (stageWr),
        .d     (mem2Next),
        .q     (mem2Q)
    );

    dataRam dataRam_inst (
        .clk    (clk),
        .req    (memReq.slave),
        .rdData (rdData)
    );

    loadWriteback loadWriteback_inst (
        .mem2   (mem2Q),
        .rdData (rdData),
        .wb     (wbNext)
    );

    // Flush only kills the instruction entering MEM2.
    pipeReg #(
        .payloadType (memPipe_pkg::wbBundle)
    ) wbReg_inst (
        .clk   (clk),
        .arstN (arstN),
        .flush (1'b0),
        .wr    (stageWr),
        .d     (wbNext),
        .q     (wbQ)
    );

    assign wbRegWr = wbQ.regWr;
    assign wbDst   = wbQ.dst;
    assign wbData  = wbQ.data;
    assign wbPc    = wbQ.pc;
    assign wbExc   = wbQ.exc;

endmodule

// ==== tb_memPipe.sv ====
// **************************************************
// Testbench for the memory back end: stimulus table,
// reference memory model, compare tasks and timeout.
// **************************************************

`timescale 1ns/1ns

`include "memPipe_cfg.svh"

module tb_memPipe;

    typedef struct packed {
        memPipe_pkg::memOpType  memOp;
        logic [`MEM_DATA_W-1:0] aluOut;
        logic [`MEM_DATA_W-1:0] storeData;
        logic [`MEM_DATA_W-1:0] pc;
        memPipe_pkg::wbSelType  wbSel;
        logic [4:0]             dst;
        logic                   regWr;
        logic                   stall;
        logic                   flush;
    } rowType;

    logic                   clk;
    logic                   arstN;
    logic                   stall;
    logic                   flush;
    logic [`MEM_DATA_W-1:0] aluOut;
    logic [`MEM_DATA_W-1:0] storeData;
    logic [`MEM_DATA_W-1:0] pc;
    memPipe_pkg::memOpType  memOp;
    memPipe_pkg::wbSelType  wbSel;
    logic [4:0]             dst;
    logic                   regWr;
    logic                   wbRegWr;
    logic [4:0]             wbDst;
    logic [`MEM_DATA_W-1:0] wbData;
    logic [`MEM_DATA_W-1:0] wbPc;
    memPipe_pkg::excType    wbExc;

    rowType                 rows[$];
    memPipe_pkg::wbBundle   expQ[$];
    logic [`MEM_DATA_W-1:0] modelMem [`MEM_DEPTH_WORDS];
    logic [`MEM_DATA_W-1:0] lastRd;
    logic [`MEM_DATA_W-1:0] nextPc = 32'h0040_0000;
    int                     errorCount = 0;
    int                     rowIdx = 0;
    int                     cycleCount = 0;
    int                     timeoutLimit = 1000;

    memPipe memPipe_inst (
        .clk       (clk),
        .arstN     (arstN),
        .stall     (stall),
        .flush     (flush),
        .aluOut    (aluOut),
        .storeData (storeData),
        .pc        (pc),
        .memOp     (memOp),
        .wbSel     (wbSel),
        .dst       (dst),
        .regWr     (regWr),
        .wbRegWr   (wbRegWr),
        .wbDst     (wbDst),
        .wbData    (wbData),
        .wbPc      (wbPc),
        .wbExc     (wbExc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit from the table length.
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: no end of the stimulus table after %0d cycles", cycleCount);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic addRow(input memPipe_pkg::memOpType op, input logic [31:0] addr,
                          input logic [31:0] sData, input memPipe_pkg::wbSelType sel,
                          input logic [4:0] rd, input logic we, input logic stl,
                          input logic fl);
        rowType r;
        r.memOp     = op;
        r.aluOut    = addr;
        r.storeData = sData;
        r.pc        = nextPc;
        r.wbSel     = sel;
        r.dst       = rd;
        r.regWr     = we;
        r.stall     = stl;
        r.flush     = fl;
        rows.push_back(r);
        nextPc = nextPc + 32'd4;
    endtask

    // Reference model of one instruction; updates memory and the read latch.
    task automatic predictResult(input rowType r, output memPipe_pkg::wbBundle e);
        logic        isLoad;
        logic        isStore;
        logic        misaligned;
        logic [31:0] wordIdx;
        logic [31:0] word;
        logic [31:0] loadVal;
        logic [7:0]  loadByte;
        logic [15:0] loadHalf;
        int          lane;
        int          halfLane;
        e = '0;
        if (!r.flush) begin
            isLoad = r.memOp inside {memPipe_pkg::opLb, memPipe_pkg::opLbu,
                                     memPipe_pkg::opLh, memPipe_pkg::opLhu,
                                     memPipe_pkg::opLw};
            isStore = r.memOp inside {memPipe_pkg::opSb, memPipe_pkg::opSh,
                                      memPipe_pkg::opSw};
            misaligned = 1'b0;
            if (r.memOp inside {memPipe_pkg::opLh, memPipe_pkg::opLhu, memPipe_pkg::opSh})
                misaligned = r.aluOut[0];
            if (r.memOp inside {memPipe_pkg::opLw, memPipe_pkg::opSw})
                misaligned = (r.aluOut[1:0] != 2'b00);
            lane     = int'(r.aluOut[1:0]);
            halfLane = int'(r.aluOut[1]);
            wordIdx  = (r.aluOut >> 2) % `MEM_DEPTH_WORDS;
            if ((isLoad || isStore) && !misaligned) begin
                // Read latch sees memory before the store lands.
                lastRd = modelMem[wordIdx];
                word   = modelMem[wordIdx];
                if (r.memOp == memPipe_pkg::opSb)
                    word[8*lane +: 8] = r.storeData[7:0];
                else if (r.memOp == memPipe_pkg::opSh)
                    word[16*halfLane +: 16] = r.storeData[15:0];
                else if (r.memOp == memPipe_pkg::opSw)
                    word = r.storeData;
                modelMem[wordIdx] = word;
            end
            loadByte = lastRd[8*lane +: 8];
            loadHalf = lastRd[16*halfLane +: 16];
            case (r.memOp)
                memPipe_pkg::opLb:  loadVal = {{24{loadByte[7]}}, loadByte};
                memPipe_pkg::opLbu: loadVal = {24'd0, loadByte};
                memPipe_pkg::opLh:  loadVal = {{16{loadHalf[15]}}, loadHalf};
                memPipe_pkg::opLhu: loadVal = {16'd0, loadHalf};
                default:            loadVal = lastRd;
            endcase
            e.regWr = r.regWr & ~misaligned;
            e.dst   = r.dst;
            e.pc    = r.pc;
            if (r.wbSel == memPipe_pkg::loadData)
                e.data = loadVal;
            else if (r.wbSel == memPipe_pkg::linkPc)
                e.data = r.pc + 32'd8;
            else
                e.data = r.aluOut;
            if (!misaligned)
                e.exc = memPipe_pkg::excNone;
            else if (isStore)
                e.exc = memPipe_pkg::excAdES;
            else
                e.exc = memPipe_pkg::excAdEL;
        end
    endtask

    task automatic checkData(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] row %0d %s: got %h, expected %h", rowIdx, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkExc(input string name, input memPipe_pkg::excType got,
                            input memPipe_pkg::excType exp);
        if (got !== exp) begin
            $display("[ERROR] row %0d %s: got %h, expected %h", rowIdx, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkBundle(input memPipe_pkg::wbBundle exp);
        checkData("wbRegWr", {31'd0, wbRegWr}, {31'd0, exp.regWr});
        checkData("wbDst", {27'd0, wbDst}, {27'd0, exp.dst});
        checkData("wbData", wbData, exp.data);
        checkData("wbPc", wbPc, exp.pc);
        checkExc("wbExc", wbExc, exp.exc);
    endtask

    task automatic buildTable();
        logic [31:0] wordA;
        logic [31:0] wordB;
        logic [31:0] wordC;
        wordA = 32'h0000_0100;
        wordB = 32'h0000_0204;
        wordC = 32'h0000_03f8;
        // Lane merge of sw, sh and sb into one word.
        addRow(memPipe_pkg::opSw, wordA, $urandom, memPipe_pkg::aluResult, 5'd0, 0, 0, 0);
        addRow(memPipe_pkg::opSh, wordA + 2, $urandom, memPipe_pkg::aluResult, 5'd0, 0, 0, 0);
        addRow(memPipe_pkg::opSb, wordA + 1, $urandom, memPipe_pkg::aluResult, 5'd0, 0, 0, 0);
        addRow(memPipe_pkg::opLw, wordA, '0, memPipe_pkg::loadData, 5'd2, 1, 0, 0);
        // Sub-word loads at every legal offset.
        for (int i = 0; i < 4; i++) begin
            addRow(memPipe_pkg::opLb, wordA + i, '0, memPipe_pkg::loadData, 5'd4, 1, 0, 0);
            addRow(memPipe_pkg::opLbu, wordA + i, '0, memPipe_pkg::loadData, 5'd5, 1, 0, 0);
        end
        for (int i = 0; i < 4; i += 2) begin
            addRow(memPipe_pkg::opLh, wordA + i, '0, memPipe_pkg::loadData, 5'd6, 1, 0, 0);
            addRow(memPipe_pkg::opLhu, wordA + i, '0, memPipe_pkg::loadData, 5'd7, 1, 0, 0);
        end
        // Sign bit set in every byte so signed and unsigned loads differ.
        addRow(memPipe_pkg::opSw, wordB, $urandom | 32'h8080_8080, memPipe_pkg::aluResult,
               5'd0, 0, 0, 0);
        addRow(memPipe_pkg::opLb, wordB + 3, '0, memPipe_pkg::loadData, 5'd8, 1, 0, 0);
        addRow(memPipe_pkg::opLh, wordB + 2, '0, memPipe_pkg::loadData, 5'd9, 1, 0, 0);
        addRow(memPipe_pkg::opLhu, wordB, '0, memPipe_pkg::loadData, 5'd10, 1, 0, 0);
        addRow(memPipe_pkg::opLbu, wordB + 1, '0, memPipe_pkg::loadData, 5'd11, 1, 0, 0);
        // ALU and link results.
        addRow(memPipe_pkg::opNone, 32'h1234_5678, '0, memPipe_pkg::aluResult, 5'd3, 1, 0, 0);
        addRow(memPipe_pkg::opNone, 32'hcafe_0001, '0, memPipe_pkg::linkPc, 5'd31, 1, 0, 0);
        addRow(memPipe_pkg::opNone, 32'h0bad_f00d, '0, memPipe_pkg::aluResult, 5'd12, 0, 0, 0);
        // Address errors, then proof that memory kept its word.
        addRow(memPipe_pkg::opLh, wordB + 1, '0, memPipe_pkg::loadData, 5'd13, 1, 0, 0);
        addRow(memPipe_pkg::opLw, wordB + 2, '0, memPipe_pkg::loadData, 5'd14, 1, 0, 0);
        addRow(memPipe_pkg::opSh, wordB + 3, $urandom, memPipe_pkg::aluResult, 5'd0, 0, 0, 0);
        addRow(memPipe_pkg::opSw, wordB + 1, $urandom, memPipe_pkg::aluResult, 5'd0, 0, 0, 0);
        addRow(memPipe_pkg::opLw, wordB, '0, memPipe_pkg::loadData, 5'd15, 1, 0, 0);
        // Flushed and stalled stores.
        addRow(memPipe_pkg::opSw, wordC, $urandom, memPipe_pkg::aluResult, 5'd0, 0, 0, 0);
        addRow(memPipe_pkg::opSw, wordC, $urandom, memPipe_pkg::aluResult, 5'd0, 0, 0, 1);
        addRow(memPipe_pkg::opLw, wordC, '0, memPipe_pkg::loadData, 5'd16, 1, 0, 0);
        addRow(memPipe_pkg::opSw, wordC, $urandom, memPipe_pkg::aluResult, 5'd0, 0, 1, 0);
        addRow(memPipe_pkg::opSw, wordC, $urandom, memPipe_pkg::aluResult, 5'd0, 0, 1, 0);
        addRow(memPipe_pkg::opLw, wordC, '0, memPipe_pkg::loadData, 5'd17, 1, 0, 0);
        // Drain the two pipeline stages.
        addRow(memPipe_pkg::opNone, '0, '0, memPipe_pkg::aluResult, 5'd0, 0, 0, 0);
        addRow(memPipe_pkg::opNone, '0, '0, memPipe_pkg::aluResult, 5'd0, 0, 0, 0);
    endtask

    initial begin
        int                   seedVal;
        rowType               r;
        memPipe_pkg::wbBundle lastOut;
        memPipe_pkg::wbBundle curExp;
        logic                 prevStall;
        seedVal   = $urandom(32'h452c);
        arstN     = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        aluOut    = '0;
        storeData = '0;
        pc        = '0;
        memOp     = memPipe_pkg::opNone;
        wbSel     = memPipe_pkg::aluResult;
        dst       = '0;
        regWr     = 1'b0;
        lastRd    = '0;
        buildTable();
        timeoutLimit = rows.size() + 16 + 20;
        // Queue starts with the reset bubble sitting in MEM2.
        expQ.push_back('0);
        lastOut   = '0;
        curExp    = '0;
        prevStall = 1'b0;
        repeat (16) @(posedge clk);
        arstN <= 1'b1;
        for (int j = 0; j < rows.size(); j++) begin
            @(posedge clk);
            // This edge moved the previous row into MEM2 unless it stalled.
            if (!prevStall) begin
                expQ.push_back(curExp);
                lastOut = expQ.pop_front();
            end
            r = rows[j];
            memOp     <= r.memOp;
            aluOut    <= r.aluOut;
            storeData <= r.storeData;
            pc        <= r.pc;
            wbSel     <= r.wbSel;
            dst       <= r.dst;
            regWr     <= r.regWr;
            stall     <= r.stall;
            flush     <= r.flush;
            if (!r.stall)
                predictResult(r, curExp);
            prevStall = r.stall;
            @(negedge clk);
            rowIdx = j;
            checkBundle(lastOut);
        end
        $display("Checks finished over %0d rows with %0d errors", rows.size(), errorCount);
        if (errorCount == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== memPipe.f ====
+incdir+.
memPipe_pkg.sv
memReqIf.sv
pipeReg.sv
memAccessStage.sv
dataRam.sv
loadWriteback.sv
memPipe.sv
tb_memPipe.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Compile and run the memory back end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns \
    --top-module tb_memPipe \
    -f memPipe.f \
    -o simv
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "Testbench passed" "$LOG"; then
    exit 0
else
    exit 1
fi
